//--- hw/arb_pkg.sv
`default_nettype none

package arb_pkg;

    localparam int NUM_PORTS    = 2;
    localparam int PORT_IDX_WID = (NUM_PORTS > 1) ? $clog2(NUM_PORTS) : 1;

    typedef logic [PORT_IDX_WID-1:0] port_idx_t;

    // Bus ownership
    typedef enum logic {
        ARB_IDLE   = 1'b0,
        ARB_LOCKED = 1'b1
    } arb_state_t;

endpackage : arb_pkg

`default_nettype wire

//--- hw/axis_ingress_pipe.sv
`timescale 1ns/1ps
`default_nettype none

module axis_ingress_pipe
    import axis_pkg::*;
(
    input  logic     from_tx,
    input  logic     aresetn,

    // Upstream side
    input  logic     in_valid,
    output logic     in_ready,
    input  axis_in_t in_beat,

    // Downstream side
    output logic     out_valid,
    input  logic     out_ready,
    output axis_in_t out_beat
);

    logic in_xfer;

    // Pull mode: take a new beat while the held one drains
    assign in_ready = !out_valid || out_ready;
    assign in_xfer  = in_valid && in_ready;

    always_ff @(posedge from_tx) begin
        if (!aresetn) begin
            out_valid <= 1'b0;
        end else if (in_xfer) begin
            out_valid <= 1'b1;
        end else if (out_ready) begin
            out_valid <= 1'b0;
        end
    end

    // Register is free or emptying whenever in_ready is high
    always_ff @(posedge from_tx) begin
        if (in_ready) begin
            out_beat <= in_beat;
        end
    end

endmodule : axis_ingress_pipe

`default_nettype wire

//--- hw/axis_merge_top.sv
`timescale 1ns/1ps
`default_nettype none

module axis_merge_top
    import axis_pkg::*;
    import arb_pkg::*;
(
    input  logic                 from_tx,
    input  logic                 aresetn,

    // Ingress ports
    input  logic [NUM_PORTS-1:0] s_valid,
    output logic [NUM_PORTS-1:0] s_ready,
    input  axis_in_t             s_beat [NUM_PORTS],

    // Merged egress
    output logic                 m_valid,
    input  logic                 m_ready,
    output axis_out_t            m_beat
);

    logic [NUM_PORTS-1:0] pipe_valid;
    logic [NUM_PORTS-1:0] pipe_ready;
    axis_in_t             pipe_beat [NUM_PORTS];

    logic                 bus_valid;
    logic                 bus_ready;
    axis_out_t            bus_beat;

    logic                 skid_valid;
    logic                 skid_ready;
    axis_out_t            skid_beat;

    // One register stage per ingress port
    for (genvar p = 0; p < NUM_PORTS; p++) begin : g_ingress
        axis_ingress_pipe axis_ingress_pipe_inst (
            .from_tx   (from_tx),
            .aresetn   (aresetn),
            .in_valid  (s_valid[p]),
            .in_ready  (s_ready[p]),
            .in_beat   (s_beat[p]),
            .out_valid (pipe_valid[p]),
            .out_ready (pipe_ready[p]),
            .out_beat  (pipe_beat[p])
        );
    end

    axis_packet_arbiter axis_packet_arbiter_inst (
        .from_tx   (from_tx),
        .aresetn   (aresetn),
        .req_valid (pipe_valid),
        .req_ready (pipe_ready),
        .req_beat  (pipe_beat),
        .bus_valid (bus_valid),
        .bus_ready (bus_ready),
        .bus_beat  (bus_beat)
    );

    axis_skid_buffer axis_skid_buffer_inst (
        .from_tx   (from_tx),
        .aresetn   (aresetn),
        .in_valid  (bus_valid),
        .in_ready  (bus_ready),
        .in_beat   (bus_beat),
        .out_valid (skid_valid),
        .out_ready (skid_ready),
        .out_beat  (skid_beat)
    );

    axis_tlast_advance axis_tlast_advance_inst (
        .from_tx   (from_tx),
        .aresetn   (aresetn),
        .in_valid  (skid_valid),
        .in_ready  (skid_ready),
        .in_beat   (skid_beat),
        .out_valid (m_valid),
        .out_ready (m_ready),
        .out_beat  (m_beat)
    );

endmodule : axis_merge_top

`default_nettype wire

//--- hw/axis_packet_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module axis_packet_arbiter
    import axis_pkg::*;
    import arb_pkg::*;
(
    input  logic                 from_tx,
    input  logic                 aresetn,

    // Ingress requests
    input  logic [NUM_PORTS-1:0] req_valid,
    output logic [NUM_PORTS-1:0] req_ready,
    input  axis_in_t             req_beat [NUM_PORTS],

    // Shared bus
    output logic                 bus_valid,
    input  logic                 bus_ready,
    output axis_out_t            bus_beat
);

    arb_state_t state;
    port_idx_t  last_grant;
    port_idx_t  grant;
    logic       bus_xfer;

    // Round-robin pick, starting after the last granted port.
    // While locked the owner is last_grant itself
    always_comb begin : pick
        port_idx_t cand;
        logic      found;
        cand  = last_grant;
        found = 1'b0;
        grant = last_grant;
        if (state == ARB_IDLE) begin
            for (int i = 1; i <= NUM_PORTS; i++) begin
                cand = port_idx_t'((int'(last_grant) + i) % NUM_PORTS);
                if (!found && req_valid[cand]) begin
                    grant = cand;
                    found = 1'b1;
                end
            end
        end
    end

    // Granted port onto the bus, source stamped into tid
    always_comb begin
        bus_valid      = req_valid[grant];
        bus_beat.tdata = req_beat[grant].tdata;
        bus_beat.tkeep = req_beat[grant].tkeep;
        bus_beat.tlast = req_beat[grant].tlast;
        bus_beat.tuser = req_beat[grant].tuser;
        bus_beat.tid   = TID_WID'(grant);
    end

    // Only the granted port sees ready
    always_comb begin
        req_ready        = '0;
        req_ready[grant] = bus_ready;
    end

    assign bus_xfer = bus_valid && bus_ready;

    // Lock on a first beat without tlast, release on the tlast beat
    always_ff @(posedge from_tx) begin
        if (!aresetn) begin
            state      <= ARB_IDLE;
            last_grant <= port_idx_t'(NUM_PORTS - 1);
        end else begin
            case (state)
                ARB_IDLE: begin
                    if (bus_xfer) begin
                        last_grant <= grant;
                        if (!bus_beat.tlast) begin
                            state <= ARB_LOCKED;
                        end
                    end
                end
                ARB_LOCKED: begin
                    if (bus_xfer && bus_beat.tlast) begin
                        state <= ARB_IDLE;
                    end
                end
                default: begin
                    state <= ARB_IDLE;
                end
            endcase
        end
    end

endmodule : axis_packet_arbiter

`default_nettype wire

//--- hw/axis_pkg.sv
`default_nettype none

package axis_pkg;

    // Beat geometry
    localparam int DATA_BYTES = 4;
    localparam int USER_WID   = 4;
    localparam int TID_WID    = 1;

    // Ingress beat, source port not yet known
    typedef struct packed {
        logic [DATA_BYTES-1:0][7:0] tdata;
        logic [DATA_BYTES-1:0]      tkeep;
        logic                       tlast;
        logic [USER_WID-1:0]        tuser;
    } axis_in_t;

    // Shared bus and egress beat, tid carries the source port
    typedef struct packed {
        logic [DATA_BYTES-1:0][7:0] tdata;
        logic [DATA_BYTES-1:0]      tkeep;
        logic                       tlast;
        logic [TID_WID-1:0]         tid;
        logic [USER_WID-1:0]        tuser;
    } axis_out_t;

endpackage : axis_pkg

`default_nettype wire

//--- hw/axis_skid_buffer.sv
`timescale 1ns/1ps
`default_nettype none

module axis_skid_buffer
    import axis_pkg::*;
(
    input  logic      from_tx,
    input  logic      aresetn,

    // Upstream side
    input  logic      in_valid,
    output logic      in_ready,
    input  axis_out_t in_beat,

    // Downstream side
    output logic      out_valid,
    input  logic      out_ready,
    output axis_out_t out_beat
);

    logic      out_ready_q;
    logic      skid_valid;
    axis_out_t skid_beat;
    logic      fwft;
    logic      ready_falling;
    logic      sample_en;

    always_ff @(posedge from_tx) begin
        if (!aresetn) begin
            out_ready_q <= 1'b0;
        end else begin
            out_ready_q <= out_ready;
        end
    end

    // Empty skid can always take a first word
    assign fwft          = in_valid && !skid_valid && !out_ready_q;
    assign ready_falling = out_ready_q && !out_ready;

    // Catch the beat in flight when downstream stalls
    assign sample_en = ready_falling || (fwft && !out_ready);

    // Upstream ready is registered, no path from out_ready
    assign in_ready = out_ready_q || fwft;

    always_ff @(posedge from_tx) begin
        if (!aresetn) begin
            skid_valid <= 1'b0;
        end else if (out_ready && skid_valid) begin
            skid_valid <= 1'b0;
        end else if (sample_en) begin
            skid_valid <= in_valid;
        end
    end

    // Track the input until a beat is parked
    always_ff @(posedge from_tx) begin
        if (!skid_valid) begin
            skid_beat <= in_beat;
        end
    end

    // Parked beat goes out first
    always_comb begin
        if (skid_valid) begin
            out_valid = 1'b1;
            out_beat  = skid_beat;
        end else begin
            out_valid = in_valid;
            out_beat  = in_beat;
        end
    end

endmodule : axis_skid_buffer

`default_nettype wire

//--- hw/axis_tlast_advance.sv
`timescale 1ns/1ps
`default_nettype none

module axis_tlast_advance
    import axis_pkg::*;
(
    input  logic      from_tx,
    input  logic      aresetn,

    // Upstream side
    input  logic      in_valid,
    output logic      in_ready,
    input  axis_out_t in_beat,

    // Downstream side
    output logic      out_valid,
    input  logic      out_ready,
    output axis_out_t out_beat
);

    logic      hold_valid;
    axis_out_t hold_beat;
    logic      skip;
    logic      in_xfer;
    logic      out_xfer;

    // Empty closing beat, never forwarded
    assign skip = in_valid && in_beat.tlast && (in_beat.tkeep == '0);

    // Held beat leaves once its successor is visible or it closes a packet
    assign out_valid = hold_valid && (hold_beat.tlast || in_valid);

    // A new beat enters only as the held one leaves
    assign in_ready = !hold_valid || out_ready;

    assign in_xfer  = in_valid && in_ready;
    assign out_xfer = out_valid && out_ready;

    always_comb begin
        out_beat       = hold_beat;
        out_beat.tlast = hold_beat.tlast || skip;
    end

    // Hold only goes empty at a packet boundary, so a skipped beat
    // arriving then is a lone empty packet
    always_ff @(posedge from_tx) begin
        if (!aresetn) begin
            hold_valid <= 1'b0;
        end else if (in_xfer) begin
            hold_valid <= !skip;
        end else if (out_xfer) begin
            hold_valid <= 1'b0;
        end
    end

    always_ff @(posedge from_tx) begin
        if (in_xfer && !skip) begin
            hold_beat <= in_beat;
        end
    end

endmodule : axis_tlast_advance

`default_nettype wire

//--- verif/axis_merge_tb.sv
`timescale 1ns/1ps
`default_nettype none

module axis_merge_tb
    import axis_pkg::*;
    import arb_pkg::*;
();

    localparam int NUM_ROWS  = 12;
    localparam int MAX_BEATS = 64;

    typedef struct {
        int                  port;
        int                  len;
        logic [USER_WID-1:0] tuser;
        bit                  empty_tail;
        int                  delay;
        int                  bp_pct;
    } pkt_row_t;

    // Port, beats incl. empty tail, tuser, empty tail, idle cycles before, stall percent
    pkt_row_t rows [NUM_ROWS] = '{
        '{0, 3, 4'h1, 1'b0, 0,  0},
        '{1, 2, 4'h2, 1'b0, 0,  0},
        '{0, 4, 4'h3, 1'b1, 0,  0},
        '{1, 1, 4'h4, 1'b0, 0,  0},
        '{0, 1, 4'h5, 1'b1, 2,  0},
        '{1, 5, 4'h6, 1'b0, 0, 30},
        '{0, 2, 4'h7, 1'b1, 1, 30},
        '{1, 3, 4'h8, 1'b1, 3, 50},
        '{0, 6, 4'h9, 1'b0, 0, 50},
        '{1, 1, 4'ha, 1'b1, 0, 50},
        '{0, 4, 4'hb, 1'b0, 5, 70},
        '{1, 4, 4'hc, 1'b0, 0, 70}
    };

    logic                 from_tx;
    logic                 aresetn;
    logic [NUM_PORTS-1:0] s_valid;
    logic [NUM_PORTS-1:0] s_ready;
    axis_in_t             s_beat [NUM_PORTS];
    logic                 m_valid;
    logic                 m_ready;
    axis_out_t            m_beat;

    int        seed = 85;
    int        timeout_limit;
    int        cycle_cnt;
    bit        first_sent;
    int        port_bp   [NUM_PORTS];
    axis_in_t  stim      [NUM_PORTS][MAX_BEATS];
    int        stim_wr   [NUM_PORTS];
    axis_out_t exp_beats [NUM_PORTS][MAX_BEATS];
    int        exp_wr    [NUM_PORTS];
    int        exp_rd    [NUM_PORTS];
    int        got_cnt   [NUM_PORTS];

    // Packet ownership seen at the output and on the shared bus
    bit        out_locked;
    port_idx_t out_owner;
    bit        stall_q;
    axis_out_t stall_beat;
    bit        bus_locked;
    port_idx_t bus_owner;
    port_idx_t bus_last = port_idx_t'(NUM_PORTS - 1);

    axis_merge_top axis_merge_top_inst (
        .from_tx (from_tx),
        .aresetn (aresetn),
        .s_valid (s_valid),
        .s_ready (s_ready),
        .s_beat  (s_beat),
        .m_valid (m_valid),
        .m_ready (m_ready),
        .m_beat  (m_beat)
    );

    initial begin
        from_tx = 1'b0;
        forever #50 from_tx = ~from_tx;
    end

    task automatic stop_run(input string why);
        $display("%s", why);
        $display("TEST FAIL");
        $fatal(1, "simulation stopped on first error");
    endtask

    task automatic check_beat(input axis_out_t got, input axis_out_t want, input string name);
        if (got.tdata !== want.tdata)
            stop_run($sformatf("FAIL %s.tdata got %h expected %h", name, got.tdata, want.tdata));
        else if (got.tkeep !== want.tkeep)
            stop_run($sformatf("FAIL %s.tkeep got %h expected %h", name, got.tkeep, want.tkeep));
        else if (got.tlast !== want.tlast)
            stop_run($sformatf("FAIL %s.tlast got %h expected %h", name, got.tlast, want.tlast));
        else if (got.tid !== want.tid)
            stop_run($sformatf("FAIL %s.tid got %h expected %h", name, got.tid, want.tid));
        else if (got.tuser !== want.tuser)
            stop_run($sformatf("FAIL %s.tuser got %h expected %h", name, got.tuser, want.tuser));
    endtask

    task automatic check_state(input port_idx_t got, input port_idx_t want, input string name);
        if (got !== want)
            stop_run($sformatf("FAIL %s got %h expected %h", name, got, want));
    endtask

    task automatic check_count(input int got, input int want, input string name);
        if (got != want)
            stop_run($sformatf("FAIL %s got %h expected %h", name, got, want));
    endtask

    // Data beats a port should deliver once empty tails are dropped
    function automatic int expected_beats(input int p);
        int n;
        int r;
        n = 0;
        for (r = 0; r < NUM_ROWS; r++) begin
            if (rows[r].port == p)
                n += rows[r].empty_tail ? rows[r].len - 1 : rows[r].len;
        end
        return n;
    endfunction

    function automatic bit all_delivered();
        bit done;
        int p;
        done = 1'b1;
        for (p = 0; p < NUM_PORTS; p++) begin
            if (exp_rd[p] != exp_wr[p])
                done = 1'b0;
        end
        return done;
    endfunction

    // Ingress beats plus expected egress beats, tlast moved off an empty tail
    task automatic build_stimulus(output int total);
        int          r;
        int          b;
        int          p;
        int          n_data;
        logic [31:0] rnd;
        axis_in_t    beat;
        axis_out_t   eb;
        total = 0;
        for (r = 0; r < NUM_ROWS; r++) begin
            p      = rows[r].port;
            n_data = rows[r].empty_tail ? rows[r].len - 1 : rows[r].len;
            for (b = 0; b < rows[r].len; b++) begin
                beat.tdata = $random(seed);
                beat.tuser = rows[r].tuser;
                beat.tlast = (b == rows[r].len - 1);
                if (b >= n_data) begin
                    beat.tkeep = '0;
                end else if (b == n_data - 1) begin
                    rnd        = $random(seed);
                    beat.tkeep = (rnd[DATA_BYTES-1:0] == '0) ? '1 : rnd[DATA_BYTES-1:0];
                end else begin
                    beat.tkeep = '1;
                end
                stim[p][stim_wr[p]] = beat;
                stim_wr[p]++;
                if (b < n_data) begin
                    eb.tdata = beat.tdata;
                    eb.tkeep = beat.tkeep;
                    eb.tuser = beat.tuser;
                    eb.tid   = TID_WID'(p);
                    eb.tlast = (b == n_data - 1);
                    exp_beats[p][exp_wr[p]] = eb;
                    exp_wr[p]++;
                end
            end
            total += rows[r].len;
        end
    endtask

    task automatic drive_port(input int p);
        int r;
        int b;
        int d;
        int idx;
        idx = 0;
        for (r = 0; r < NUM_ROWS; r++) begin
            if (rows[r].port == p) begin
                for (d = 0; d < rows[r].delay; d++) begin
                    @(negedge from_tx);
                    s_valid[p] = 1'b0;
                end
                for (b = 0; b < rows[r].len; b++) begin
                    @(negedge from_tx);
                    port_bp[p] = rows[r].bp_pct;
                    s_valid[p] = 1'b1;
                    s_beat[p]  = stim[p][idx];
                    first_sent = 1'b1;
                    idx++;
                    do @(posedge from_tx); while (s_ready[p] !== 1'b1);
                end
            end
        end
        @(negedge from_tx);
        s_valid[p] = 1'b0;
    endtask

    // Sink stalls with the higher stall percent of the active rows
    task automatic drive_sink();
        int unsigned roll;
        int          pct;
        logic        ready_next;
        forever begin
            @(posedge from_tx);
            pct        = (port_bp[0] > port_bp[1]) ? port_bp[0] : port_bp[1];
            roll       = $unsigned($random(seed)) % 100;
            ready_next = (roll >= pct);
            @(negedge from_tx);
            m_ready = ready_next;
        end
    endtask

    always @(posedge from_tx) begin : watchdog
        cycle_cnt++;
        if (cycle_cnt > timeout_limit)
            stop_run($sformatf("Run timed out after %0d cycles with beats outstanding", cycle_cnt));
    end

    // Round robin and packet lock, checked where the grant is made
    always @(posedge from_tx) begin : bus_grant_check
        port_idx_t got;
        port_idx_t want;
        if (aresetn && axis_merge_top_inst.bus_valid && axis_merge_top_inst.bus_ready) begin
            got = port_idx_t'(axis_merge_top_inst.bus_beat.tid);
            if (!bus_locked) begin
                if (axis_merge_top_inst.pipe_valid[0] && axis_merge_top_inst.pipe_valid[1])
                    want = (bus_last == 0) ? 1 : 0;
                else
                    want = axis_merge_top_inst.pipe_valid[1] ? 1 : 0;
                check_state(got, want, "bus grant");
                bus_last = got;
            end else begin
                check_state(got, bus_owner, "bus_beat.tid");
            end
            bus_owner  = got;
            bus_locked = !axis_merge_top_inst.bus_beat.tlast;
        end
    end

    always @(posedge from_tx) begin : out_check
        port_idx_t tid_now;
        if (aresetn) begin
            if (!first_sent && m_valid !== 1'b0) begin
                stop_run("m_valid rose before any packet was sent");
            end else if (stall_q && m_valid !== 1'b1) begin
                stop_run("m_valid dropped while m_ready was holding it stalled");
            end else begin
                if (stall_q)
                    check_beat(m_beat, stall_beat, "m_beat under stall");
                if (m_valid && m_ready) begin
                    if ($isunknown(m_beat.tid)) begin
                        stop_run("m_beat.tid is unknown on a delivered beat");
                    end else begin
                        tid_now = port_idx_t'(m_beat.tid);
                        if (out_locked)
                            check_state(tid_now, out_owner, "m_beat.tid");
                        if (exp_rd[tid_now] == exp_wr[tid_now]) begin
                            stop_run($sformatf("Port %0d delivered an unexpected beat", tid_now));
                        end else begin
                            check_beat(m_beat, exp_beats[tid_now][exp_rd[tid_now]], "m_beat");
                            exp_rd[tid_now]++;
                            got_cnt[tid_now]++;
                        end
                        out_owner  = tid_now;
                        out_locked = !m_beat.tlast;
                    end
                end
                stall_q    = m_valid && !m_ready;
                stall_beat = m_beat;
            end
        end
    end

    initial begin : main
        int total;
        int p;
        aresetn = 1'b0;
        s_valid = '0;
        m_ready = 1'b0;
        for (p = 0; p < NUM_PORTS; p++)
            s_beat[p] = '0;
        build_stimulus(total);
        timeout_limit = 16 + 20 * total;
        repeat (16) @(posedge from_tx);
        @(negedge from_tx);
        aresetn = 1'b1;
        fork
            drive_sink();
        join_none
        fork
            drive_port(0);
            drive_port(1);
        join
        while (!all_delivered())
            @(posedge from_tx);
        // Idle tail, any stray beat would fail the output check
        repeat (20) @(posedge from_tx);
        check_count(got_cnt[0], expected_beats(0), "port 0 beat count");
        check_count(got_cnt[1], expected_beats(1), "port 1 beat count");
        $display("TEST PASS");
        $finish;
    end

endmodule : axis_merge_tb

`default_nettype wire

//--- verilog.f
hw/axis_pkg.sv
hw/arb_pkg.sv
hw/axis_ingress_pipe.sv
hw/axis_packet_arbiter.sv
hw/axis_skid_buffer.sv
hw/axis_tlast_advance.sv
hw/axis_merge_top.sv
verif/axis_merge_tb.sv
